//--- common/opn_cfg_pkg.sv
// Clock divider defaults, timer sizes, sample and DAC types for the opn_dac core

package opn_cfg_pkg;

    // Prescaler defaults
    localparam int CEN_DIV_DEF    = 6;   // Clocks per internal clock enable
    localparam int TICK_SLOTS_DEF = 24;  // Clock enables per sample tick

    // CPU bus busy window after a data write, in clocks
    localparam int BUSY_CYCLES_DEF = 32;

    // Timer B only advances once every 16 sample ticks
    localparam int TMRB_SUBDIV = 16;

    // Audio widths
    localparam int SAMPLE_W  = 16;
    localparam int DAC_W     = 8;
    localparam int DAC_SHIFT = 6;        // Centered DAC code to sample scaling

    // Timer widths
    localparam int TMRA_W = 10;
    localparam int TMRB_W = 8;

    typedef logic signed [SAMPLE_W-1:0] sample_t;  // Signed output sample
    typedef logic        [DAC_W-1:0]    dac_t;     // Offset binary DAC code

    typedef logic [TMRA_W-1:0] tmra_t;
    typedef logic [TMRB_W-1:0] tmrb_t;

endpackage

//--- common/opn_reg_pkg.sv
// Register addresses, timer control bits, DAC and pan bits, status bit positions

package opn_reg_pkg;

    // Register map, single bank
    localparam logic [7:0] REG_TMRA_HI  = 8'h24;  // Timer A bits 9..2
    localparam logic [7:0] REG_TMRA_LO  = 8'h25;  // Timer A bits 1..0
    localparam logic [7:0] REG_TMRB     = 8'h26;
    localparam logic [7:0] REG_TMR_CTL  = 8'h27;
    localparam logic [7:0] REG_DAC_DATA = 8'h2A;
    localparam logic [7:0] REG_DAC_EN   = 8'h2B;
    localparam logic [7:0] REG_PAN_CH6  = 8'hB6;

    // Timer control byte
    localparam int CTL_LOAD_A_BIT   = 0;
    localparam int CTL_LOAD_B_BIT   = 1;
    localparam int CTL_FLAGEN_A_BIT = 2;
    localparam int CTL_FLAGEN_B_BIT = 3;
    localparam int CTL_CLR_A_BIT    = 4;
    localparam int CTL_CLR_B_BIT    = 5;

    // DAC enable in REG_DAC_EN
    localparam int DAC_EN_BIT = 7;

    // Channel 6 panning in REG_PAN_CH6
    localparam int PAN_L_BIT = 7;
    localparam int PAN_R_BIT = 6;

    // Status byte read on the data port
    localparam int STAT_BUSY_BIT  = 7;
    localparam int STAT_FLAGB_BIT = 1;
    localparam int STAT_FLAGA_BIT = 0;

endpackage

//--- rtl/opn_clk_div.sv
// Two stage prescaler for the internal clock enable and the sample tick

`timescale 1ns/1ps

module opn_clk_div #(
    parameter int CEN_DIV    = opn_cfg_pkg::CEN_DIV_DEF,
    parameter int TICK_SLOTS = opn_cfg_pkg::TICK_SLOTS_DEF
) (
    input  logic clk,
    input  logic reset,
    output logic clk_en,
    output logic tick
);

    localparam int CEN_W  = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam int SLOT_W = (TICK_SLOTS > 1) ? $clog2(TICK_SLOTS) : 1;

    logic [CEN_W-1:0]  cen_cnt;
    logic [SLOT_W-1:0] slot_cnt;    // Stands in for the operator slot counter
    logic              cen_last;
    logic              slot_last;

    assign cen_last  = (cen_cnt == CEN_W'(CEN_DIV - 1));
    assign slot_last = (slot_cnt == SLOT_W'(TICK_SLOTS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            cen_cnt  <= '0;
            slot_cnt <= '0;
            clk_en   <= 1'b0;
            tick     <= 1'b0;
        end else begin
            cen_cnt <= cen_last ? '0 : cen_cnt + 1'b1;
            if (cen_last) begin
                slot_cnt <= slot_last ? '0 : slot_cnt + 1'b1;
            end
            clk_en <= cen_last;
            tick   <= cen_last && slot_last;  // Start of the sample period
        end
    end

endmodule

//--- rtl/opn_mmr.sv
// CPU bus decode, register file, busy counter, status read and interrupt output

`timescale 1ns/1ps

module opn_mmr #(
    parameter int BUSY_CYCLES = opn_cfg_pkg::BUSY_CYCLES_DEF
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cs_n,
    input  logic                 wr_n,
    input  logic                 rd_n,
    input  logic [1:0]           addr,    // Bit 1 selects the second bank, not present
    input  logic [7:0]           din,
    input  logic                 flag_a,
    input  logic                 flag_b,
    output logic [7:0]           dout,
    output logic                 irq_n,
    output opn_cfg_pkg::tmra_t   tmra_value,
    output opn_cfg_pkg::tmrb_t   tmrb_value,
    output logic                 load_a,
    output logic                 load_b,
    output logic                 flag_en_a,
    output logic                 flag_en_b,
    output logic                 clr_a,
    output logic                 clr_b,
    output opn_cfg_pkg::dac_t    dac_code,
    output logic                 dac_en,
    output logic                 pan_l,
    output logic                 pan_r
);

    import opn_reg_pkg::*;

    localparam int BUSY_W = $clog2(BUSY_CYCLES + 1);

    logic              write;
    logic              addr_wr;
    logic              data_wr;
    logic [7:0]        reg_addr;    // Latched by the address port
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;
    logic [7:0]        status;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_addr <= '0;
        end else if (addr_wr) begin
            reg_addr <= din;
        end
    end

    // Register file, written on the data port
    always_ff @(posedge clk) begin
        if (reset) begin
            tmra_value <= '0;
            tmrb_value <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            flag_en_a  <= 1'b0;
            flag_en_b  <= 1'b0;
            clr_a      <= 1'b0;
            clr_b      <= 1'b0;
            dac_code   <= '0;
            dac_en     <= 1'b0;
            pan_l      <= 1'b0;
            pan_r      <= 1'b0;
        end else begin
            // Load and clear last one cycle
            load_a <= 1'b0;
            load_b <= 1'b0;
            clr_a  <= 1'b0;
            clr_b  <= 1'b0;
            if (data_wr) begin
                case (reg_addr)
                    REG_TMRA_HI:  tmra_value <= {din, tmra_value[1:0]};
                    REG_TMRA_LO:  tmra_value <= {tmra_value[9:2], din[1:0]};
                    REG_TMRB:     tmrb_value <= din;
                    REG_TMR_CTL: begin
                        load_a    <= din[CTL_LOAD_A_BIT];
                        load_b    <= din[CTL_LOAD_B_BIT];
                        flag_en_a <= din[CTL_FLAGEN_A_BIT];  // Held until next write
                        flag_en_b <= din[CTL_FLAGEN_B_BIT];
                        clr_a     <= din[CTL_CLR_A_BIT];
                        clr_b     <= din[CTL_CLR_B_BIT];
                    end
                    REG_DAC_DATA: dac_code <= din;
                    REG_DAC_EN:   dac_en   <= din[DAC_EN_BIT];
                    REG_PAN_CH6: begin
                        pan_l <= din[PAN_L_BIT];
                        pan_r <= din[PAN_R_BIT];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Busy window restarts on every data write
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

    always_comb begin
        status                 = '0;
        status[STAT_BUSY_BIT]  = busy;
        status[STAT_FLAGB_BIT] = flag_b;
        status[STAT_FLAGA_BIT] = flag_a;
    end

    assign dout  = (!cs_n && !rd_n) ? status : 8'h00;  // Idle bus reads as zero
    assign irq_n = !(flag_a || flag_b);

endmodule

//--- timers/opn_timer.sv
// Reloadable up counting timer with sub divider and overflow flag

`timescale 1ns/1ps

module opn_timer #(
    parameter type cnt_t   = opn_cfg_pkg::tmrb_t,
    parameter int  SUB_DIV = 1
) (
    input  logic clk,
    input  logic reset,
    input  logic tick,
    input  logic load,
    input  cnt_t start,
    input  logic flag_en,
    input  logic clr,
    output logic flag
);

    localparam int SUB_W = (SUB_DIV > 1) ? $clog2(SUB_DIV) : 1;

    logic [SUB_W-1:0] sub_cnt;
    cnt_t             cnt;
    logic             advance;
    logic             wrap;

    // With SUB_DIV of 1 every tick advances
    assign advance = tick && (sub_cnt == SUB_W'(SUB_DIV - 1));
    assign wrap    = advance && (&cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            sub_cnt <= '0;
        end else if (load) begin
            sub_cnt <= '0;          // Full period after a load
        end else if (advance) begin
            sub_cnt <= '0;
        end else if (tick) begin
            sub_cnt <= sub_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= start;
        end else if (wrap) begin
            cnt <= start;           // Overflow reloads
        end else if (advance) begin
            cnt <= cnt_t'(cnt + 1'b1);
        end
    end

    // Clear wins over a set in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            flag <= 1'b0;
        end else if (clr) begin
            flag <= 1'b0;
        end else if (wrap && flag_en) begin
            flag <= 1'b1;
        end
    end

endmodule

//--- rtl/opn_dac_mix.sv
// Channel 6 DAC conversion, left and right panning, output registers and sample strobe

`timescale 1ns/1ps

module opn_dac_mix (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  opn_cfg_pkg::dac_t    dac_code,
    input  logic                 dac_en,
    input  logic                 pan_l,
    input  logic                 pan_r,
    output opn_cfg_pkg::sample_t snd_left,
    output opn_cfg_pkg::sample_t snd_right,
    output logic                 snd_sample
);

    import opn_cfg_pkg::*;

    logic signed [DAC_W-1:0] centered;
    sample_t                 dac_sample;
    sample_t                 gated;

    // Inverting the MSB gives code minus 128 in two's complement
    assign centered   = signed'({~dac_code[DAC_W-1], dac_code[DAC_W-2:0]});
    assign dac_sample = sample_t'(centered) <<< DAC_SHIFT;
    assign gated      = dac_en ? dac_sample : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            snd_left   <= '0;
            snd_right  <= '0;
            snd_sample <= 1'b0;
        end else begin
            if (tick) begin
                snd_left  <= pan_l ? gated : '0;
                snd_right <= pan_r ? gated : '0;
            end
            snd_sample <= tick;     // High while fresh values first show
        end
    end

endmodule

//--- rtl/opn_top.sv
// Top level of the opn_dac core with prescaler, register block, two timers and DAC mixer

`timescale 1ns/1ps

module opn_top #(
    parameter int CEN_DIV     = opn_cfg_pkg::CEN_DIV_DEF,
    parameter int TICK_SLOTS  = opn_cfg_pkg::TICK_SLOTS_DEF,
    parameter int BUSY_CYCLES = opn_cfg_pkg::BUSY_CYCLES_DEF
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cs_n,
    input  logic                 wr_n,
    input  logic                 rd_n,
    input  logic [1:0]           addr,
    input  logic [7:0]           din,
    output logic [7:0]           dout,
    output logic                 irq_n,
    output opn_cfg_pkg::sample_t snd_left,
    output opn_cfg_pkg::sample_t snd_right,
    output logic                 snd_sample
);

    import opn_cfg_pkg::*;

    logic  tick;
    logic  flag_a, flag_b;
    tmra_t tmra_value;
    tmrb_t tmrb_value;
    logic  load_a, load_b;
    logic  flag_en_a, flag_en_b;
    logic  clr_a, clr_b;
    dac_t  dac_code;
    logic  dac_en;
    logic  pan_l, pan_r;

    // Clock enable only feeds the tick here
    opn_clk_div #(
        .CEN_DIV    (CEN_DIV),
        .TICK_SLOTS (TICK_SLOTS)
    ) u_clk_div (
        .clk    (clk),
        .reset  (reset),
        .clk_en (),
        .tick   (tick)
    );

    opn_mmr #(
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_mmr (
        .clk        (clk),
        .reset      (reset),
        .cs_n       (cs_n),
        .wr_n       (wr_n),
        .rd_n       (rd_n),
        .addr       (addr),
        .din        (din),
        .flag_a     (flag_a),
        .flag_b     (flag_b),
        .dout       (dout),
        .irq_n      (irq_n),
        .tmra_value (tmra_value),
        .tmrb_value (tmrb_value),
        .load_a     (load_a),
        .load_b     (load_b),
        .flag_en_a  (flag_en_a),
        .flag_en_b  (flag_en_b),
        .clr_a      (clr_a),
        .clr_b      (clr_b),
        .dac_code   (dac_code),
        .dac_en     (dac_en),
        .pan_l      (pan_l),
        .pan_r      (pan_r)
    );

    opn_timer #(
        .cnt_t   (tmra_t),
        .SUB_DIV (1)
    ) u_timer_a (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .load    (load_a),
        .start   (tmra_value),
        .flag_en (flag_en_a),
        .clr     (clr_a),
        .flag    (flag_a)
    );

    opn_timer #(
        .cnt_t   (tmrb_t),
        .SUB_DIV (TMRB_SUBDIV)
    ) u_timer_b (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .load    (load_b),
        .start   (tmrb_value),
        .flag_en (flag_en_b),
        .clr     (clr_b),
        .flag    (flag_b)
    );

    opn_dac_mix u_dac_mix (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .dac_code   (dac_code),
        .dac_en     (dac_en),
        .pan_l      (pan_l),
        .pan_r      (pan_r),
        .snd_left   (snd_left),
        .snd_right  (snd_right),
        .snd_sample (snd_sample)
    );

endmodule

//--- test/opn_tb_clk.sv
// Testbench clock and synchronous reset generator

`timescale 1ns/1ps

module opn_tb_clk #(
    parameter int HALF_PERIOD  = 2,    // 4 ns clock
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;     // Released just after an edge
    end

endmodule

//--- test/opn_tb_assert.sv
// Concurrent checks on irq_n against the status byte, busy window length and snd_sample pulse width

`timescale 1ns/1ps

module opn_tb_assert #(
    parameter int BUSY_CYCLES = 32
) (
    input logic       clk,
    input logic       reset,
    input logic       cs_n,
    input logic       rd_n,
    input logic [7:0] dout,
    input logic       irq_n,
    input logic       busy,
    input logic       snd_sample
);

    import opn_reg_pkg::*;

    int busy_run;    // Cycles since busy last rose

    always @(posedge clk) begin
        if (reset) begin
            busy_run <= 0;
        end else if (busy) begin
            busy_run <= busy_run + 1;
        end else begin
            busy_run <= 0;
        end
    end

    // On a status read the flag bits must agree with the interrupt line
    irq_matches_status: assert property (@(posedge clk) disable iff (reset)
        (!cs_n && !rd_n) |-> (irq_n == !(dout[STAT_FLAGA_BIT] || dout[STAT_FLAGB_BIT])))
        else $error("irq_n does not match the status flag bits");

    busy_bounded: assert property (@(posedge clk) disable iff (reset)
        busy_run <= BUSY_CYCLES + 1)
        else $error("busy stayed high longer than the busy window");

    sample_single: assert property (@(posedge clk) disable iff (reset)
        snd_sample |=> !snd_sample)
        else $error("snd_sample high for more than one cycle");

endmodule

bind opn_top opn_tb_assert #(
    .BUSY_CYCLES (BUSY_CYCLES)
) u_assert (
    .clk        (clk),
    .reset      (reset),
    .cs_n       (cs_n),
    .rd_n       (rd_n),
    .dout       (dout),
    .irq_n      (irq_n),
    .busy       (u_mmr.busy),
    .snd_sample (snd_sample)
);

//--- test/opn_tb.sv
// Testbench top with DAC stimulus table, CPU bus tasks, timer checks and summary

`timescale 1ns/1ps

module opn_tb;

    import opn_cfg_pkg::*;
    import opn_reg_pkg::*;

    localparam int TICK_CLKS    = CEN_DIV_DEF * TICK_SLOTS_DEF;   // Clocks per sample
    localparam int BUSY_LIMIT   = BUSY_CYCLES_DEF + 8;
    localparam int SAMPLE_LIMIT = TICK_CLKS + 16;
    localparam logic [1:0] K_WRITE = 2'd0;
    localparam logic [1:0] K_CHECK = 2'd1;

    typedef struct packed {
        logic [1:0]  kind;
        logic [7:0]  ra;
        logic [7:0]  value;
        logic [15:0] exp_l;
        logic [15:0] exp_r;
    } step_t;

    logic       clk;
    logic       reset;
    logic       cs_n;
    logic       wr_n;
    logic       rd_n;
    logic [1:0] addr;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq_n;
    sample_t    snd_left;
    sample_t    snd_right;
    logic       snd_sample;

    step_t steps[$];
    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    cycle_cnt;
    int    write_cycle;    // Cycle of the last data write

    opn_tb_clk u_clk (
        .clk   (clk),
        .reset (reset)
    );

    opn_top uut (
        .clk        (clk),
        .reset      (reset),
        .cs_n       (cs_n),
        .wr_n       (wr_n),
        .rd_n       (rd_n),
        .addr       (addr),
        .din        (din),
        .dout       (dout),
        .irq_n      (irq_n),
        .snd_left   (snd_left),
        .snd_right  (snd_right),
        .snd_sample (snd_sample)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Code minus 128, times 64
    function automatic logic [15:0] dac_expect(input logic [7:0] code);
        int v;
        v = (int'(code) - 128) * 64;
        return v[15:0];
    endfunction

    function automatic void add_step(input logic [1:0] kind, input logic [7:0] ra,
                                     input logic [7:0] value, input logic [15:0] exp_l,
                                     input logic [15:0] exp_r);
        steps.push_back(step_t'({kind, ra, value, exp_l, exp_r}));
    endfunction

    // One code write followed by the sample it should produce
    function automatic void add_code(input logic [7:0] code, input logic l_on,
                                     input logic r_on);
        logic [15:0] s;
        s = dac_expect(code);
        add_step(K_WRITE, REG_DAC_DATA, code, 16'h0, 16'h0);
        add_step(K_CHECK, 8'h00, 8'h00, l_on ? s : 16'h0, r_on ? s : 16'h0);
    endfunction

    task automatic check_hex(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic drive_idle();
        cs_n = 1'b1;
        wr_n = 1'b1;
        rd_n = 1'b1;
        addr = 2'b00;
        din  = 8'h00;
    endtask

    task automatic read_status(output logic [7:0] st);
        @(posedge clk);
        #1;
        cs_n = 1'b0;
        rd_n = 1'b0;
        @(negedge clk);
        st = dout;    // Combinational read, settled mid cycle
        @(posedge clk);
        #1;
        drive_idle();
    endtask

    task automatic wait_busy_clear();
        logic [7:0] st;
        int         n;
        n = 0;
        read_status(st);
        check_true(st[STAT_BUSY_BIT], "busy did not rise after a data write");
        while (st[STAT_BUSY_BIT] && n < BUSY_LIMIT) begin
            read_status(st);
            n++;
        end
        check_true(!st[STAT_BUSY_BIT], "timeout waiting for busy to clear");
    endtask

    task automatic write_reg(input logic [7:0] ra, input logic [7:0] value);
        @(posedge clk);
        #1;
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'b00;      // Address port
        din  = ra;
        @(posedge clk);
        #1;
        addr = 2'b01;      // Data port
        din  = value;
        @(posedge clk);
        #1;
        write_cycle = cycle_cnt;
        drive_idle();
        wait_busy_clear();
    endtask

    task automatic wait_sample(output logic [15:0] l, output logic [15:0] r);
        int n;
        n = 0;
        @(negedge clk);
        while (!snd_sample && n < SAMPLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        check_true(snd_sample, "timeout waiting for snd_sample");
        l = snd_left;
        r = snd_right;
    endtask

    task automatic wait_flag(input int bit_pos, input int limit, output logic [7:0] st);
        int n;
        n = 0;
        read_status(st);
        while (!st[bit_pos] && n < limit) begin
            read_status(st);
            n++;
        end
        check_true(st[bit_pos], "timeout waiting for a timer flag");
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        logic [7:0]  st;
        logic [15:0] l;
        logic [15:0] r;
        int          err_start;
        int          n;
        void'($urandom(35664));
        drive_idle();

        n = 0;
        while (reset && n < 20) begin
            @(posedge clk);
            n++;
        end
        check_true(!reset, "reset was never released");
        #1;

        // Quiet state after reset
        err_start = errors;
        read_status(st);
        check_hex("status", 16'(st), 16'h0);
        check_hex("irq_n", 16'(irq_n), 16'h1);
        wait_sample(l, r);
        check_hex("snd_left", l, 16'h0);
        check_hex("snd_right", r, 16'h0);
        end_test("reset", err_start);

        // DAC codes with both pans, then pan and enable cases
        add_step(K_WRITE, REG_DAC_EN, 8'h80, 16'h0, 16'h0);
        add_step(K_WRITE, REG_PAN_CH6, 8'hC0, 16'h0, 16'h0);
        add_code(8'h00, 1'b1, 1'b1);
        add_code(8'h80, 1'b1, 1'b1);
        add_code(8'hFF, 1'b1, 1'b1);
        add_code(8'h7F, 1'b1, 1'b1);
        add_code(8'h01, 1'b1, 1'b1);
        for (int i = 0; i < 6; i++) begin
            add_code(8'($urandom), 1'b1, 1'b1);
        end
        add_step(K_WRITE, REG_PAN_CH6, 8'h80, 16'h0, 16'h0);
        add_code(8'hA5, 1'b1, 1'b0);
        add_step(K_WRITE, REG_PAN_CH6, 8'h40, 16'h0, 16'h0);
        add_code(8'h3C, 1'b0, 1'b1);
        add_step(K_WRITE, REG_PAN_CH6, 8'hC0, 16'h0, 16'h0);
        add_step(K_WRITE, REG_DAC_EN, 8'h00, 16'h0, 16'h0);
        add_code(8'hE0, 1'b0, 1'b0);     // Disabled DAC reads 0 on both

        err_start = errors;
        foreach (steps[i]) begin
            if (steps[i].kind == K_WRITE) begin
                write_reg(steps[i].ra, steps[i].value);
            end else begin
                wait_sample(l, r);
                check_hex("snd_left", l, steps[i].exp_l);
                check_hex("snd_right", r, steps[i].exp_r);
            end
        end
        end_test("dac table", err_start);

        // Timer A at 0x3FF overflows on the first tick
        err_start = errors;
        write_reg(REG_TMRA_HI, 8'hFF);
        write_reg(REG_TMRA_LO, 8'h03);
        write_reg(REG_TMR_CTL, 8'((1 << CTL_LOAD_A_BIT) | (1 << CTL_FLAGEN_A_BIT)));
        wait_flag(STAT_FLAGA_BIT, 3 * TICK_CLKS, st);
        @(negedge clk);
        check_hex("irq_n", 16'(irq_n), 16'h0);
        check_hex("dout", 16'(dout), 16'h0);     // Bus idle while flag A is set
        write_reg(REG_TMR_CTL, 8'(1 << CTL_CLR_A_BIT));
        for (int i = 0; i < 4; i++) begin
            read_status(st);
            check_hex("flag_a", 16'(st[STAT_FLAGA_BIT]), 16'h0);
            @(negedge clk);
            check_hex("irq_n", 16'(irq_n), 16'h1);
            wait_sample(l, r);
        end
        end_test("timer a", err_start);

        // Timer B at 0xFF needs 16 ticks for one count
        err_start = errors;
        write_reg(REG_TMRB, 8'hFF);
        write_reg(REG_TMR_CTL, 8'((1 << CTL_LOAD_B_BIT) | (1 << CTL_FLAGEN_B_BIT)));
        n = write_cycle;
        wait_flag(STAT_FLAGB_BIT, 20 * TICK_CLKS, st);
        n = cycle_cnt - n;
        check_true(n >= 15 * TICK_CLKS, "flag B was set before 16 ticks had passed");
        write_reg(REG_TMR_CTL, 8'(1 << CTL_CLR_B_BIT));
        read_status(st);
        check_hex("flag_b", 16'(st[STAT_FLAGB_BIT]), 16'h0);
        @(negedge clk);
        check_hex("irq_n", 16'(irq_n), 16'h1);
        end_test("timer b", err_start);

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- opn_dac.f
common/opn_cfg_pkg.sv
common/opn_reg_pkg.sv
rtl/opn_clk_div.sv
rtl/opn_mmr.sv
timers/opn_timer.sv
rtl/opn_dac_mix.sv
rtl/opn_top.sv
test/opn_tb_clk.sv
test/opn_tb_assert.sv
test/opn_tb.sv

//--- run.sh
#!/bin/sh
# Build the opn_dac testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f opn_dac.f \
    --top-module opn_tb \
    -o opn_sim

if ! ./obj_dir/opn_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
grep -q "TB PASSED" sim.log
